// ==== hdl/isaPkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////////////////////
// Instruction set of the accumulator core.
////////////////////////////////////////////////////////////////////////////

package isaPkg;

	// Opcodes live in the top nibble of every instruction word.
	// Codes 11 to 15 are unused and decode as NOP.
	typedef enum logic [3:0] {
		OpNop  = 4'd0,
		OpLdi  = 4'd1,
		OpAddi = 4'd2,
		OpAdd  = 4'd3,
		OpSub  = 4'd4,
		OpAnd  = 4'd5,
		OpXor  = 4'd6,
		OpLd   = 4'd7,
		OpSt   = 4'd8,
		OpBeqz = 4'd9,
		OpJmp  = 4'd10
	} opcodeT;

	// Field positions inside the 16-bit word.
	// Bits 10 to 8 are reserved and ignored by the decoder.
	localparam int OpcodeMsb = 15;
	localparam int OpcodeLsb = 12;
	// Zero selects accumulator A, one selects accumulator B.
	localparam int AccSelBit = 11;
	// The immediate doubles as data address and branch target.
	localparam int ImmMsb = 7;
	localparam int ImmLsb = 0;
	localparam int ImmWidth = ImmMsb - ImmLsb + 1;

	// Operations the execute stage can perform.
	// The zero code matters, since a bubble carries it.
	typedef enum logic [2:0] {
		AluPassImm = 3'd0,
		AluAdd     = 3'd1,
		AluSub     = 3'd2,
		AluAnd     = 3'd3,
		AluXor     = 3'd4,
		AluPassMem = 3'd5
	} aluOpT;

endpackage

`default_nettype wire

// ==== hdl/corePkg.sv ====
`default_nettype none

package corePkg;

	localparam int DataWidth = 8;
	localparam int InstrWidth = 16;
	// Room for a 4K-word program; branches stay within a 256-word page.
	localparam int PcWidth = 12;

	// Fetch to decode.
	typedef struct packed {
		logic [InstrWidth-1:0] instr;
		logic [PcWidth-1:0]    pc;
	} ifIdT;

	// Decode to execute. Operand a is the selected accumulator.
	typedef struct packed {
		logic [DataWidth-1:0] opA;
		logic [DataWidth-1:0] opB;
		logic [DataWidth-1:0] imm;
		isaPkg::aluOpT        aluOp;
		logic                 acc;
		logic                 writeEn;
		logic                 memRead;
		logic                 memWrite;
		logic                 branchZero;
		logic                 jump;
		logic [PcWidth-1:0]   brTarget;
	} idExT;

	// Execute to memory.
	typedef struct packed {
		logic [DataWidth-1:0] result;
		logic [DataWidth-1:0] addr;
		logic [DataWidth-1:0] storeData;
		logic                 acc;
		logic                 writeEn;
		logic                 memRead;
		logic                 memWrite;
	} exMemT;

	// Memory to writeback.
	typedef struct packed {
		logic [DataWidth-1:0] data;
		logic                 acc;
		logic                 writeEn;
	} memWbT;

	// Bubbles are all zero, so every enable and branch flag is off.
	localparam ifIdT IfIdBubble = '0;
	localparam idExT IdExBubble = '0;
	localparam exMemT ExMemBubble = '0;
	localparam memWbT MemWbBubble = '0;

endpackage

`default_nettype wire

// ==== hdl/pipeReg.sv ====
`timescale 1ns/1ns
`default_nettype none

// One stage boundary of the pipeline.
// The payload type changes per boundary, the behaviour does not.
module pipeReg #(
	parameter type payloadT = logic,
	parameter payloadT BubbleVal = '0
) (
	input  logic    clk,
	input  logic    rstN,
	input  logic    clear,
	input  payloadT d,
	output payloadT q
);

	// Reset and clear both leave a bubble behind.
	// A clear wins over new data, so a stopped core drains to bubbles.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			q <= BubbleVal;
		end else if (clear) begin
			q <= BubbleVal;
		end else begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// ==== hdl/fetchStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module fetchStage #(
	parameter int ImemDepth = 64
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           run,
	input  logic                           progWe,
	input  logic [$clog2(ImemDepth)-1:0]   progAddr,
	input  logic [corePkg::InstrWidth-1:0] progData,
	input  logic                           brTaken,
	input  logic [corePkg::PcWidth-1:0]    brTarget,
	output logic [corePkg::InstrWidth-1:0] instr,
	output logic [corePkg::PcWidth-1:0]    pc
);

	import isaPkg::*;
	import corePkg::*;

	localparam int PcBits = $clog2(ImemDepth);

	logic [InstrWidth-1:0] imem [ImemDepth];
	logic [PcBits-1:0] pcQ;
	logic [InstrWidth-1:0] nopWord;

	////////////////////////////////////////////////////////////////////////////
	// Instruction memory. The load port only works while the core is stopped.
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (progWe && !run) begin
			imem[progAddr] <= progData;
		end
	end

	// The PC sits at 0 while stopped, so the next run starts from the top.
	// A taken branch overrides the increment; the two younger instructions
	// already in flight are not touched and complete as delay slots.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			pcQ <= '0;
		end else if (!run) begin
			pcQ <= '0;
		end else if (brTaken) begin
			pcQ <= brTarget[PcBits-1:0];
		end else begin
			pcQ <= pcQ + 1'b1;
		end
	end

	// NOP word built from the opcode, all other fields zero.
	always_comb begin
		nopWord = '0;
		nopWord[OpcodeMsb:OpcodeLsb] = OpNop;
	end

	assign instr = run ? imem[pcQ] : nopWord;
	// The upper PC bits are always zero for this memory size.
	assign pc = {{(PcWidth - PcBits){1'b0}}, pcQ};

endmodule

`default_nettype wire

// ==== hdl/decodeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
	input  logic [corePkg::InstrWidth-1:0] instr,
	input  logic [corePkg::PcWidth-1:0]    pc,
	input  logic [corePkg::DataWidth-1:0]  accA,
	input  logic [corePkg::DataWidth-1:0]  accB,
	output logic                           rdSel,
	output corePkg::idExT                  ctrl
);

	import isaPkg::*;
	import corePkg::*;

	opcodeT opcode;
	logic [ImmWidth-1:0] imm;

	assign opcode = opcodeT'(instr[OpcodeMsb:OpcodeLsb]);
	assign imm = instr[ImmMsb:ImmLsb];

	// The accumulator bank hands back the selected accumulator on port a
	// and the other one on port b.
	assign rdSel = instr[AccSelBit];

	////////////////////////////////////////////////////////////////////////////
	// Control decode.
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		ctrl = IdExBubble;
		ctrl.opA = accA;
		ctrl.opB = accB;
		ctrl.imm = imm;
		ctrl.acc = rdSel;
		// Targets are absolute within the page the branch sits in.
		ctrl.brTarget = {pc[PcWidth-1:ImmWidth], imm};
		case (opcode)
			OpLdi: begin
				ctrl.aluOp = AluPassImm;
				ctrl.writeEn = 1'b1;
			end
			OpAddi: begin
				// The immediate takes the place of the second operand.
				ctrl.aluOp = AluAdd;
				ctrl.opB = imm;
				ctrl.writeEn = 1'b1;
			end
			OpAdd: begin
				ctrl.aluOp = AluAdd;
				ctrl.writeEn = 1'b1;
			end
			OpSub: begin
				ctrl.aluOp = AluSub;
				ctrl.writeEn = 1'b1;
			end
			OpAnd: begin
				ctrl.aluOp = AluAnd;
				ctrl.writeEn = 1'b1;
			end
			OpXor: begin
				ctrl.aluOp = AluXor;
				ctrl.writeEn = 1'b1;
			end
			OpLd: begin
				ctrl.aluOp = AluPassMem;
				ctrl.writeEn = 1'b1;
				ctrl.memRead = 1'b1;
			end
			// Store data is operand a, the selected accumulator.
			OpSt: ctrl.memWrite = 1'b1;
			// The zero test in execute looks at operand a as well.
			OpBeqz: ctrl.branchZero = 1'b1;
			OpJmp: ctrl.jump = 1'b1;
			// NOP and the unused codes leave every enable off.
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/accBank.sv ====
`timescale 1ns/1ns
`default_nettype none

module accBank (
	input  logic                          clk,
	input  logic                          rstN,
	input  logic                          rdSel,
	input  logic                          we,
	input  logic                          wAcc,
	input  logic [corePkg::DataWidth-1:0] wData,
	output logic [corePkg::DataWidth-1:0] accA,
	output logic [corePkg::DataWidth-1:0] accB
);

	import corePkg::*;

	// Entry 0 is accumulator A, entry 1 is accumulator B.
	logic [DataWidth-1:0] acc [2];

	// Written on the edge that closes the writeback cycle.
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			acc[0] <= '0;
			acc[1] <= '0;
		end else if (we) begin
			acc[wAcc] <= wData;
		end
	end

	// Port a returns the selected accumulator, port b the other one.
	// A write in progress shows up on the matching port right away,
	// which shortens the producer to consumer distance by one.
	assign accA = (we && (wAcc == rdSel)) ? wData : acc[rdSel];
	assign accB = (we && (wAcc != rdSel)) ? wData : acc[~rdSel];

endmodule

`default_nettype wire

// ==== hdl/executeStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeStage (
	input  corePkg::idExT               ctrl,
	output corePkg::exMemT              result,
	output logic                        brTaken,
	output logic [corePkg::PcWidth-1:0] brTarget
);

	import isaPkg::*;
	import corePkg::*;

	logic [DataWidth-1:0] aluOut;

	////////////////////////////////////////////////////////////////////////////
	// ALU. All arithmetic wraps at the data width.
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.aluOp)
			AluPassImm: aluOut = ctrl.imm;
			AluAdd:     aluOut = ctrl.opA + ctrl.opB;
			AluSub:     aluOut = ctrl.opA - ctrl.opB;
			AluAnd:     aluOut = ctrl.opA & ctrl.opB;
			AluXor:     aluOut = ctrl.opA ^ ctrl.opB;
			// The memory stage puts the loaded word in place of this.
			AluPassMem: aluOut = '0;
			default:    aluOut = '0;
		endcase
	end

	// Memory accesses address with the immediate.
	// A store writes the selected accumulator, carried as operand a.
	always_comb begin
		result = ExMemBubble;
		result.result = aluOut;
		result.addr = ctrl.imm;
		result.storeData = ctrl.opA;
		result.acc = ctrl.acc;
		result.writeEn = ctrl.writeEn;
		result.memRead = ctrl.memRead;
		result.memWrite = ctrl.memWrite;
	end

	////////////////////////////////////////////////////////////////////////////
	// Branch resolution.
	////////////////////////////////////////////////////////////////////////////

	// A bubble has both flags low, so it can never redirect fetch.
	assign brTaken = ctrl.jump | (ctrl.branchZero & (ctrl.opA == '0));
	assign brTarget = ctrl.brTarget;

endmodule

`default_nettype wire

// ==== hdl/memStage.sv ====
`timescale 1ns/1ns
`default_nettype none

module memStage #(
	parameter int DmemDepth = 16
) (
	input  logic           clk,
	input  corePkg::exMemT in,
	output corePkg::memWbT out
);

	import corePkg::*;

	localparam int IdxBits = $clog2(DmemDepth);

	// The data memory keeps its contents across a core reset.
	logic [DataWidth-1:0] dmem [DmemDepth];
	logic [IdxBits-1:0] idx;

	// Addresses past the end wrap around.
	assign idx = IdxBits'(in.addr % DmemDepth);

	always_ff @(posedge clk) begin
		if (in.memWrite) begin
			dmem[idx] <= in.storeData;
		end
	end

	// The read is combinational. A load that directly follows a store to the
	// same byte already sees the new value, since the store wrote last edge.
	always_comb begin
		out = MemWbBubble;
		out.data = in.memRead ? dmem[idx] : in.result;
		out.acc = in.acc;
		out.writeEn = in.writeEn;
	end

endmodule

`default_nettype wire

// ==== hdl/pipelineTop.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipelineTop #(
	parameter int ImemDepth = 64,
	parameter int DmemDepth = 16
) (
	input  logic                           clk,
	input  logic                           rstN,
	input  logic                           run,
	input  logic                           progWe,
	input  logic [$clog2(ImemDepth)-1:0]   progAddr,
	input  logic [corePkg::InstrWidth-1:0] progData,
	output logic                           wbValid,
	output logic                           wbAcc,
	output logic [corePkg::DataWidth-1:0]  wbData
);

	import corePkg::*;

	logic clearStages;
	logic [InstrWidth-1:0] fInstr;
	logic [PcWidth-1:0] fPc;
	logic brTaken;
	logic [PcWidth-1:0] brTarget;
	logic rdSel;
	logic [DataWidth-1:0] accA;
	logic [DataWidth-1:0] accB;
	ifIdT ifIdD;
	ifIdT ifIdQ;
	idExT idExD;
	idExT idExQ;
	exMemT exMemD;
	exMemT exMemQ;
	memWbT memWbD;
	memWbT memWbQ;

	// Stopping the core drains every boundary to bubbles.
	assign clearStages = !run;

	////////////////////////////////////////////////////////////////////////////
	// Fetch and decode.
	////////////////////////////////////////////////////////////////////////////
	fetchStage #(.ImemDepth(ImemDepth)) fetch (
		.clk, .rstN, .run, .progWe, .progAddr, .progData,
		.brTaken, .brTarget, .instr(fInstr), .pc(fPc)
	);

	assign ifIdD = '{instr: fInstr, pc: fPc};

	pipeReg #(.payloadT(ifIdT), .BubbleVal(IfIdBubble)) ifIdReg (
		.clk, .rstN, .clear(clearStages), .d(ifIdD), .q(ifIdQ)
	);

	decodeStage decode (
		.instr(ifIdQ.instr), .pc(ifIdQ.pc), .accA, .accB, .rdSel, .ctrl(idExD)
	);

	// Written from the writeback boundary, read by decode.
	accBank accs (
		.clk, .rstN, .rdSel, .we(memWbQ.writeEn), .wAcc(memWbQ.acc),
		.wData(memWbQ.data), .accA, .accB
	);

	pipeReg #(.payloadT(idExT), .BubbleVal(IdExBubble)) idExReg (
		.clk, .rstN, .clear(clearStages), .d(idExD), .q(idExQ)
	);

	////////////////////////////////////////////////////////////////////////////
	// Execute, memory and writeback.
	////////////////////////////////////////////////////////////////////////////
	executeStage execute (
		.ctrl(idExQ), .result(exMemD), .brTaken, .brTarget
	);

	pipeReg #(.payloadT(exMemT), .BubbleVal(ExMemBubble)) exMemReg (
		.clk, .rstN, .clear(clearStages), .d(exMemD), .q(exMemQ)
	);

	memStage #(.DmemDepth(DmemDepth)) mem (
		.clk, .in(exMemQ), .out(memWbD)
	);

	pipeReg #(.payloadT(memWbT), .BubbleVal(MemWbBubble)) memWbReg (
		.clk, .rstN, .clear(clearStages), .d(memWbD), .q(memWbQ)
	);

	// The writeback ports mirror what the accumulator bank is being given.
	assign wbValid = memWbQ.writeEn;
	assign wbAcc = memWbQ.acc;
	assign wbData = memWbQ.data;

endmodule

`default_nettype wire

// ==== verif/pipelineProps.sv ====
`timescale 1ns/1ns
`default_nettype none

// Protocol rules of the core that hold for every program.
module pipelineProps (
	input logic clk,
	input logic rstN,
	input logic run,
	input logic progWe,
	input logic wbValid,
	input logic brTaken
);

	// Reset leaves every stage register holding a bubble.
	wbQuietInReset: assert property (@(posedge clk) !rstN |-> !wbValid)
		else $error("wbValid high while reset is asserted");

	// The first instruction needs four edges to reach the writeback boundary.
	wbQuietAfterStart: assert property (@(posedge clk) disable iff (!rstN)
		$rose(run) |-> !wbValid [*4])
		else $error("wbValid high within four cycles of run rising");

	// A bubble in execute must still give a clean branch decision.
	brTakenKnown: assert property (@(posedge clk) disable iff (!rstN)
		!$isunknown(brTaken))
		else $error("brTaken is unknown");

	// The instruction memory is only loaded while the core is stopped.
	noLoadWhileRunning: assert property (@(posedge clk) disable iff (!rstN)
		!(progWe && run))
		else $error("progWe high while run is high");

endmodule

bind pipelineTop pipelineProps props (
	.clk, .rstN, .run, .progWe, .wbValid, .brTaken
);

`default_nettype wire

// ==== verif/wbChecker.sv ====
`timescale 1ns/1ns
`default_nettype none

// Compares every writeback of the core with the next expected one.
module wbChecker (
	input logic                          clk,
	input logic                          rstN,
	input logic                          wbValid,
	input logic                          wbAcc,
	input logic [corePkg::DataWidth-1:0] wbData
);

	import corePkg::*;

	// Each entry is {accumulator, data}.
	logic [DataWidth:0] expQ [$];
	string testName = "idle";
	int testErrors = 0;
	int seenCount = 0;
	int errorCount = 0;
	int testCount = 0;
	int failedTests = 0;

	task automatic pushExpected(input logic acc, input logic [DataWidth-1:0] data);
		expQ.push_back({acc, data});
	endtask

	task automatic startTest(input string name);
		testName = name;
		testErrors = 0;
		seenCount = 0;
		expQ.delete();
	endtask

	// Anything still queued at the end was never written back.
	task automatic finishTest();
		if (expQ.size() != 0) begin
			$display("%s: %0d expected writebacks never appeared", testName, expQ.size());
			testErrors++;
			expQ.delete();
		end
		testCount++;
		errorCount += testErrors;
		if (testErrors == 0) begin
			$display("%-12s passed with %0d writebacks", testName, seenCount);
		end else begin
			failedTests++;
			$display("%-12s failed with %0d errors", testName, testErrors);
		end
	endtask

	task automatic printSummary();
		$display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errorCount);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// The outputs are sampled on the rising edge, before the stage registers
	// move, so the value seen is the one held during the writeback cycle.
	////////////////////////////////////////////////////////////////////////////
	always @(posedge clk) begin
		logic [DataWidth:0] want;
		if (rstN && wbValid) begin
			seenCount++;
			if (expQ.size() == 0) begin
				$display("%s: writeback to %s of 0x%02h came with none expected",
					testName, wbAcc ? "B" : "A", wbData);
				testErrors++;
			end else begin
				want = expQ.pop_front();
				if ({wbAcc, wbData} !== want) begin
					$display("[ERROR] %s: expected %s=0x%02h, actual %s=0x%02h", testName,
						want[DataWidth] ? "B" : "A", want[DataWidth-1:0],
						wbAcc ? "B" : "A", wbData);
					testErrors++;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/pipelineTb.sv ====
`timescale 1ns/1ns
`default_nettype none

module pipelineTb;

	import isaPkg::*;
	import corePkg::*;

	localparam int ImemDepth = 64;
	localparam int DmemDepth = 16;
	localparam int ClkPeriod = 40;
	localparam int AddrBits = $clog2(ImemDepth);
	// Run lengths in cycles. The last three fetches of a run never retire.
	localparam int RunDirected = 40;
	localparam int RunRandom = 48;
	localparam int ResetAfter = 14;
	localparam int LoadCycles = ImemDepth + 3;
	localparam int TotalCycles = 4 + 5 * (LoadCycles + RunDirected + 3)
		+ 3 * (LoadCycles + RunRandom + 3) + (LoadCycles + ResetAfter + 7);

	logic clk;
	logic rstN;
	logic run;
	logic progWe;
	logic [AddrBits-1:0] progAddr;
	logic [InstrWidth-1:0] progData;
	logic wbValid;
	logic wbAcc;
	logic [DataWidth-1:0] wbData;

	logic [InstrWidth-1:0] prog [ImemDepth];
	int progLen;
	logic [DataWidth:0] expQ [$];
	logic [31:0] lcgState;

	pipelineTop #(.ImemDepth(ImemDepth), .DmemDepth(DmemDepth)) uut (
		.clk, .rstN, .run, .progWe, .progAddr, .progData, .wbValid, .wbAcc, .wbData
	);

	wbChecker wbChk (.clk, .rstN, .wbValid, .wbAcc, .wbData);

	always #(ClkPeriod / 2) clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Program building.
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [InstrWidth-1:0] encode(opcodeT op, logic sel, logic [7:0] imm);
		logic [InstrWidth-1:0] w;
		w = '0;
		w[OpcodeMsb:OpcodeLsb] = op;
		w[AccSelBit] = sel;
		w[ImmMsb:ImmLsb] = imm;
		return w;
	endfunction

	// Unused words are NOPs that carry their own address in the low bits.
	function automatic void clearProgram();
		for (int i = 0; i < ImemDepth; i++) begin
			prog[i] = {4'(OpNop), 12'(i)};
		end
		progLen = 0;
	endfunction

	function automatic void emit(logic [InstrWidth-1:0] w);
		prog[progLen] = w;
		progLen++;
	endfunction

	// Two NOPs follow, so any later reader sees the result.
	function automatic void emitSpaced(logic [InstrWidth-1:0] w);
		emit(w);
		emit(encode(OpNop, 1'b0, 8'h00));
		emit(encode(OpNop, 1'b0, 8'h00));
	endfunction

	function automatic logic [31:0] lcgNext();
		lcgState = (lcgState * 32'd1103515245 + 32'd12345) & 32'h7fffffff;
		return lcgState >> 8;
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Reference model. Runs the program in order by the ISA rules, with two
	// delay slots after a taken branch, and queues each accumulator write.
	////////////////////////////////////////////////////////////////////////////
	function automatic void modelProgram(int nInstr);
		logic [7:0] acc [2];
		logic [7:0] mem [DmemDepth];
		logic [InstrWidth-1:0] w;
		opcodeT op;
		logic sel;
		logic [7:0] imm;
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] res;
		logic wr;
		logic taken;
		int pc;
		int nextPc;
		int countdown;
		int target;
		acc[0] = '0;
		acc[1] = '0;
		pc = 0;
		countdown = 0;
		target = 0;
		expQ.delete();
		for (int n = 0; n < nInstr; n++) begin
			w = prog[pc];
			op = opcodeT'(w[OpcodeMsb:OpcodeLsb]);
			sel = w[AccSelBit];
			imm = w[ImmMsb:ImmLsb];
			a = acc[sel];
			b = acc[!sel];
			wr = 1'b1;
			taken = 1'b0;
			res = '0;
			case (op)
				OpLdi: res = imm;
				OpAddi: res = a + imm;
				OpAdd: res = a + b;
				OpSub: res = a - b;
				OpAnd: res = a & b;
				OpXor: res = a ^ b;
				OpLd: res = mem[imm % DmemDepth];
				OpSt: begin
					mem[imm % DmemDepth] = a;
					wr = 1'b0;
				end
				OpBeqz: begin
					wr = 1'b0;
					taken = (a == 8'h00);
				end
				OpJmp: begin
					wr = 1'b0;
					taken = 1'b1;
				end
				default: wr = 1'b0;
			endcase
			if (wr) begin
				acc[sel] = res;
				expQ.push_back({sel, res});
			end
			nextPc = (pc + 1) % ImemDepth;
			if (countdown > 0) begin
				countdown--;
				if (countdown == 0) nextPc = target;
			end
			if (taken) begin
				countdown = 2;
				target = imm % ImemDepth;
			end
			pc = nextPc;
		end
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus. All inputs change on the falling edge.
	////////////////////////////////////////////////////////////////////////////
	task automatic loadProgram();
		for (int i = 0; i < ImemDepth; i++) begin
			@(negedge clk);
			progWe = 1'b1;
			progAddr = AddrBits'(i);
			progData = prog[i];
		end
		@(negedge clk);
		progWe = 1'b0;
	endtask

	task automatic handExpected();
		while (expQ.size() != 0) begin
			logic [DataWidth:0] e;
			e = expQ.pop_front();
			wbChk.pushExpected(e[DataWidth], e[DataWidth-1:0]);
		end
	endtask

	task automatic runTest(input string name, input int runCycles);
		wbChk.startTest(name);
		modelProgram(runCycles - 3);
		handExpected();
		loadProgram();
		@(negedge clk);
		run = 1'b1;
		repeat (runCycles) @(negedge clk);
		run = 1'b0;
		repeat (2) @(negedge clk);
		wbChk.finishTest();
	endtask

	function automatic void startProgram();
		clearProgram();
		emit(encode(OpLdi, 1'b0, 8'h00));
		emitSpaced(encode(OpLdi, 1'b1, 8'h00));
	endfunction

	// Random ALU program; every writer is followed by two NOPs.
	function automatic void randomProgram();
		opcodeT ops [6];
		logic [31:0] r;
		ops = '{OpLdi, OpAddi, OpAdd, OpSub, OpAnd, OpXor};
		startProgram();
		for (int i = 0; i < 13; i++) begin
			r = lcgNext();
			emitSpaced(encode(ops[r % 6], r[8], r[22:15]));
		end
	endfunction

	initial begin
		int ranTests;
		clk = 1'b0;
		rstN = 1'b0;
		run = 1'b0;
		progWe = 1'b0;
		progAddr = '0;
		progData = '0;
		lcgState = 32'd7;
		repeat (4) @(negedge clk);
		rstN = 1'b1;

		// Arithmetic with wrap-around.
		startProgram();
		emit(encode(OpLdi, 1'b0, 8'd200));
		emitSpaced(encode(OpLdi, 1'b1, 8'd100));
		emitSpaced(encode(OpAdd, 1'b0, 8'h00));
		emitSpaced(encode(OpAddi, 1'b1, 8'd250));
		emitSpaced(encode(OpSub, 1'b1, 8'h00));
		emitSpaced(encode(OpSub, 1'b0, 8'h00));
		emitSpaced(encode(OpAddi, 1'b0, 8'hff));
		runTest("arith", RunDirected);

		// Logic operations with both accumulators as targets.
		startProgram();
		emit(encode(OpLdi, 1'b0, 8'hf0));
		emitSpaced(encode(OpLdi, 1'b1, 8'h3c));
		emitSpaced(encode(OpAnd, 1'b0, 8'h00));
		emitSpaced(encode(OpXor, 1'b1, 8'h00));
		emitSpaced(encode(OpAnd, 1'b1, 8'h00));
		emitSpaced(encode(OpLdi, 1'b1, 8'h5a));
		emitSpaced(encode(OpXor, 1'b0, 8'h00));
		runTest("logic", RunDirected);

		// Store and load back, with addresses that wrap.
		startProgram();
		emitSpaced(encode(OpLdi, 1'b0, 8'h5a));
		emit(encode(OpSt, 1'b0, 8'd3));
		emitSpaced(encode(OpLdi, 1'b1, 8'hc3));
		emit(encode(OpSt, 1'b1, 8'h17));
		emitSpaced(encode(OpLd, 1'b0, 8'd7));
		emitSpaced(encode(OpLd, 1'b1, 8'h13));
		emitSpaced(encode(OpAdd, 1'b0, 8'h00));
		runTest("memory", RunDirected);

		// Branches at fixed addresses; 7 to 9 and 17 to 18 must be skipped.
		clearProgram();
		prog[0] = encode(OpLdi, 1'b0, 8'h00);
		prog[1] = encode(OpLdi, 1'b1, 8'h00);
		prog[4] = encode(OpBeqz, 1'b0, 8'd10);
		prog[5] = encode(OpLdi, 1'b1, 8'h11);
		prog[6] = encode(OpLdi, 1'b1, 8'h22);
		prog[7] = encode(OpLdi, 1'b0, 8'h99);
		prog[8] = encode(OpLdi, 1'b0, 8'h98);
		prog[9] = encode(OpLdi, 1'b0, 8'h97);
		prog[12] = encode(OpBeqz, 1'b1, 8'd40);
		prog[13] = encode(OpLdi, 1'b0, 8'h33);
		prog[14] = encode(OpJmp, 1'b0, 8'd20);
		prog[15] = encode(OpLdi, 1'b1, 8'h44);
		prog[16] = encode(OpLdi, 1'b1, 8'h55);
		prog[17] = encode(OpLdi, 1'b0, 8'hee);
		prog[18] = encode(OpLdi, 1'b0, 8'hed);
		prog[20] = encode(OpLdi, 1'b0, 8'h66);
		prog[23] = encode(OpAdd, 1'b1, 8'h00);
		runTest("branch", RunDirected);

		for (int i = 0; i < 3; i++) begin
			randomProgram();
			runTest($sformatf("random%0d", i), RunRandom);
		end

		// Reset in the middle of a run. Writebacks still in flight are lost.
		startProgram();
		emit(encode(OpLdi, 1'b0, 8'h21));
		emitSpaced(encode(OpLdi, 1'b1, 8'h42));
		emitSpaced(encode(OpAdd, 1'b0, 8'h00));
		emitSpaced(encode(OpXor, 1'b1, 8'h00));
		wbChk.startTest("reset");
		modelProgram(ResetAfter - 4);
		handExpected();
		loadProgram();
		@(negedge clk);
		run = 1'b1;
		repeat (ResetAfter) @(negedge clk);
		rstN = 1'b0;
		run = 1'b0;
		repeat (4) @(negedge clk);
		rstN = 1'b1;
		repeat (2) @(negedge clk);
		wbChk.finishTest();

		// No initial clear here, so the results rely on the reset values.
		clearProgram();
		emitSpaced(encode(OpAddi, 1'b0, 8'd3));
		emitSpaced(encode(OpAddi, 1'b1, 8'd4));
		emitSpaced(encode(OpAdd, 1'b0, 8'h00));
		emitSpaced(encode(OpSub, 1'b1, 8'h00));
		runTest("afterReset", RunDirected);

		wbChk.printSummary();
		ranTests = wbChk.testCount;
		if (wbChk.errorCount == 0 && ranTests == 9) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	// Twice the expected length of the whole run.
	initial begin
		#(TotalCycles * 2 * ClkPeriod);
		$display("Timeout: the tests did not complete in time");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/isaPkg.sv
hdl/corePkg.sv
hdl/pipeReg.sv
hdl/fetchStage.sv
hdl/decodeStage.sv
hdl/accBank.sv
hdl/executeStage.sv
hdl/memStage.sv
hdl/pipelineTop.sv
verif/pipelineProps.sv
verif/wbChecker.sv
verif/pipelineTb.sv

// ==== Bender.yml ====
package:
  name: acc_pipeline

sources:
  - files:
      - hdl/isaPkg.sv
      - hdl/corePkg.sv
      - hdl/pipeReg.sv
      - hdl/fetchStage.sv
      - hdl/decodeStage.sv
      - hdl/accBank.sv
      - hdl/executeStage.sv
      - hdl/memStage.sv
      - hdl/pipelineTop.sv
  - target: simulation
    files:
      - verif/pipelineProps.sv
      - verif/wbChecker.sv
      - verif/pipelineTb.sv
